// ==== logic/div_pkg.sv ====
`default_nettype none

package div_pkg;

    // **********************************************************************
    // operand widths
    // **********************************************************************
    typedef logic [63:0] xlen_t;   // full register word
    typedef logic [31:0] half_t;   // word-form operand

    localparam int DIV_STEPS = 64; // one quotient bit per step

    // **********************************************************************
    // request and tag
    // **********************************************************************
    typedef enum logic [1:0] {
        DIV_OP_DIV  = 2'd0, // signed quotient
        DIV_OP_DIVU = 2'd1, // unsigned quotient
        DIV_OP_REM  = 2'd2, // signed remainder
        DIV_OP_REMU = 2'd3  // unsigned remainder
    } div_op_t;

    typedef struct packed {
        div_op_t op;
        logic    word;     // 32-bit form
        xlen_t   dividend;
        xlen_t   divisor;
    } div_req_t;

    // carried alongside the magnitudes so fixup can restore signs
    typedef struct packed {
        logic neg_quot;
        logic neg_rem;
        logic by_zero;
        logic want_rem;
        logic word;
    } div_tag_t;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_t;

endpackage

`default_nettype wire

// ==== logic/div_operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
    input  div_pkg::div_req_t req,
    output div_pkg::xlen_t    abs_dividend,
    output div_pkg::xlen_t    abs_divisor,
    output div_pkg::div_tag_t tag
);
    import div_pkg::*;

    logic  is_signed;
    logic  want_rem;
    half_t dividend_lo;
    half_t divisor_lo;
    xlen_t dividend_ext;
    xlen_t divisor_ext;
    logic  dividend_neg;
    logic  divisor_neg;
    logic  divisor_zero;

    assign is_signed = (req.op == DIV_OP_DIV) || (req.op == DIV_OP_REM);
    assign want_rem  = (req.op == DIV_OP_REM) || (req.op == DIV_OP_REMU);

    assign dividend_lo = req.dividend[31:0];
    assign divisor_lo  = req.divisor[31:0];

    // **********************************************************************
    // word extension ignores the upper halves of word operands
    // **********************************************************************
    always_comb begin
        if (req.word) begin
            dividend_ext = {{32{is_signed & dividend_lo[31]}}, dividend_lo};
            divisor_ext  = {{32{is_signed & divisor_lo[31]}}, divisor_lo};
        end else begin
            dividend_ext = req.dividend;
            divisor_ext  = req.divisor;
        end
    end

    assign dividend_neg = is_signed & dividend_ext[63];
    assign divisor_neg  = is_signed & divisor_ext[63];
    assign divisor_zero = (divisor_ext == '0);

    // the most negative value maps onto itself and is still the right unsigned magnitude
    assign abs_dividend = dividend_neg ? (~dividend_ext + 64'd1) : dividend_ext;
    assign abs_divisor  = divisor_neg  ? (~divisor_ext + 64'd1)  : divisor_ext;

    always_comb begin
        tag          = '0;
        tag.neg_quot = (dividend_neg ^ divisor_neg) & ~divisor_zero;
        tag.neg_rem  = dividend_neg;                   // remainder follows the dividend
        tag.by_zero  = divisor_zero;
        tag.want_rem = want_rem;
        tag.word     = req.word;
    end

endmodule

`default_nettype wire

// ==== logic/div_radix2_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_radix2_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              flush,
    input  div_pkg::xlen_t    abs_dividend,
    input  div_pkg::xlen_t    abs_divisor,
    input  div_pkg::div_tag_t tag,
    output logic              ready,
    output logic              done,
    output div_pkg::xlen_t    quot,
    output div_pkg::xlen_t    rem,
    output div_pkg::div_tag_t tag_q
);
    import div_pkg::*;

    localparam int CNT_W = $clog2(DIV_STEPS) + 1;

    div_state_t     state;
    logic [CNT_W-1:0] step_cnt;
    logic [127:0]   work;        // {partial remainder, quotient bits}
    xlen_t          divisor_q;   // stays aligned to the upper half
    logic           accept;
    logic [64:0]    rem_shift;   // shifted partial remainder with the carry out
    logic [64:0]    rem_diff;
    logic [127:0]   work_next;

    assign accept = start & (ready | flush);

    // **********************************************************************
    // one restoring step
    // **********************************************************************
    assign rem_shift = work[127:63];
    assign rem_diff  = rem_shift - {1'b0, divisor_q};

    always_comb begin
        if (!rem_diff[64]) begin                       // no borrow so the difference is kept
            work_next = {rem_diff[63:0], work[62:0], 1'b1};
        end else begin
            work_next = {rem_shift[63:0], work[62:0], 1'b0};
        end
    end

    // **********************************************************************
    // control
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
            ready    <= 1'b1;
        end else if (accept) begin                     // new request wins over flush
            state    <= DIV_RUN;
            step_cnt <= '0;
            ready    <= 1'b0;
        end else if (flush) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
            ready    <= 1'b1;
        end else begin
            case (state)
                DIV_RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == CNT_W'(DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    state    <= DIV_IDLE;
                    step_cnt <= '0;
                    ready    <= 1'b1;                  // rises with out_valid
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (accept) begin
            work      <= {64'd0, abs_dividend};
            divisor_q <= abs_divisor;
            tag_q     <= tag;
        end else if (state == DIV_RUN) begin
            work <= work_next;
        end
    end

    assign done = (state == DIV_DONE) & ~flush;        // flushed result is dropped
    assign quot = work[63:0];
    assign rem  = work[127:64];

    // **********************************************************************
    // checks
    // **********************************************************************
    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        step_cnt <= CNT_W'(DIV_STEPS));

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

    a_busy_not_ready: assert property (@(posedge clk) disable iff (rst)
        (state == DIV_RUN) |-> !ready);

endmodule

`default_nettype wire

// ==== logic/div_result_fixup.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_result_fixup (
    input  logic              clk,
    input  logic              rst,
    input  logic              done,
    input  div_pkg::xlen_t    quot,
    input  div_pkg::xlen_t    rem,
    input  div_pkg::div_tag_t tag_q,
    output logic              out_valid,
    output div_pkg::xlen_t    result
);
    import div_pkg::*;

    xlen_t quot_signed;
    xlen_t rem_signed;
    xlen_t quot_final;
    xlen_t selected;
    xlen_t result_next;

    // **********************************************************************
    // result rules in order
    // **********************************************************************
    assign quot_signed = tag_q.neg_quot ? (~quot + 64'd1) : quot;
    assign rem_signed  = tag_q.neg_rem  ? (~rem + 64'd1)  : rem;

    // divide by zero gives an all-ones quotient
    assign quot_final = tag_q.by_zero ? '1 : quot_signed;

    assign selected = tag_q.want_rem ? rem_signed : quot_final;

    always_comb begin
        if (tag_q.word) begin
            result_next = {{32{selected[31]}}, selected[31:0]};
        end else begin
            result_next = selected;
        end
    end

    // **********************************************************************
    // output register
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            result <= result_next;
        end
    end

    a_out_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid);

endmodule

`default_nettype wire

// ==== logic/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              div_valid,
    input  logic              flush,
    input  div_pkg::div_req_t req,
    output logic              div_ready,
    output logic              out_valid,
    output div_pkg::xlen_t    result
);
    import div_pkg::*;

    xlen_t    abs_dividend;
    xlen_t    abs_divisor;
    div_tag_t tag;
    div_tag_t tag_q;
    logic     done;
    xlen_t    quot;
    xlen_t    rem;

    // **********************************************************************
    // prep -> core -> fixup
    // **********************************************************************
    div_operand_prep prep0 (
        .req          (req),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .tag          (tag)
    );

    div_radix2_core core0 (
        .clk          (clk),
        .rst          (rst),
        .start        (div_valid),    // acceptance is qualified inside the core
        .flush        (flush),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .tag          (tag),
        .ready        (div_ready),
        .done         (done),
        .quot         (quot),
        .rem          (rem),
        .tag_q        (tag_q)
    );

    div_result_fixup fixup0 (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .quot      (quot),
        .rem       (rem),
        .tag_q     (tag_q),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== sim/div_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;
    import div_pkg::*;

    localparam int MAX_VECTORS = 64;
    localparam int FIELDS      = 6;        // kind, op, word, dividend, divisor, expected
    localparam int LATENCY     = 65;       // acceptance edge to out_valid
    localparam int FLUSH_DELAY = 10;       // busy edges before the flush is driven

    localparam logic [63:0] KIND_NORMAL    = 64'd0;
    localparam logic [63:0] KIND_FLUSH_MID = 64'd1;
    localparam logic [63:0] KIND_FLUSH_NEW = 64'd2;
    localparam logic [63:0] FILL_BASE      = 64'hdead_0000_0000_0000;

    logic     clk = 1'b0;
    logic     rst;
    logic     div_valid;
    logic     flush;
    div_req_t req;
    logic     div_ready;
    logic     out_valid;
    xlen_t    result;

    logic [63:0] golden [0:MAX_VECTORS*FIELDS-1];
    int          n_vec;
    int          n_flush;
    int          cycle_cnt   = 0;
    int          cycle_limit = 100000;  // replaced once the vectors are counted

    div_unit dut0 (
        .clk       (clk),
        .rst       (rst),
        .div_valid (div_valid),
        .flush     (flush),
        .req       (req),
        .div_ready (div_ready),
        .out_valid (out_valid),
        .result    (result)
    );

    always #10 clk = ~clk;                 // 20 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: result never arrived");
            $display("Checks failed");
            $fatal(1);
        end
    end

    // **********************************************************************
    // helpers
    // **********************************************************************
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // returns on the acceptance edge
    task automatic send_request(input logic [63:0] op, input logic [63:0] word,
                                input xlen_t dividend, input xlen_t divisor,
                                input logic with_flush);
        div_req_t r;
        r.op       = div_op_t'(op[1:0]);
        r.word     = word[0];
        r.dividend = dividend;
        r.divisor  = divisor;
        @(posedge clk);
        req       <= r;
        div_valid <= 1'b1;
        flush     <= with_flush;
        @(posedge clk);
        div_valid <= 1'b0;
        flush     <= 1'b0;
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!div_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic hold_busy(input int edges);
        repeat (edges) begin
            @(negedge clk);
            check_value("div_ready", 64'(div_ready), 64'd0);
        end
    endtask

    // counts edges from acceptance until out_valid shows up
    task automatic collect_result(input xlen_t expected);
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        @(negedge clk);
        check_value("div_ready", 64'(div_ready), 64'd0);
        while (!seen) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (out_valid) begin
                seen = 1'b1;
            end else begin
                check_value("div_ready", 64'(div_ready), 64'd0);
            end
        end
        check_value("latency", 64'(edges), 64'(LATENCY));
        check_value("result", result, expected);
        check_value("div_ready", 64'(div_ready), 64'd1);
        @(negedge clk);
        check_value("out_valid", 64'(out_valid), 64'd0);  // one cycle only
    endtask

    task automatic flush_idle();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_value("div_ready", 64'(div_ready), 64'd1);
    endtask

    task automatic watch_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("out_valid", 64'(out_valid), 64'd0);
        end
    endtask

    // **********************************************************************
    // one golden line
    // **********************************************************************
    task automatic run_vector(input int idx);
        logic [63:0] kind;
        logic [63:0] op;
        logic [63:0] word;
        xlen_t       dividend;
        xlen_t       divisor;
        xlen_t       expected;
        kind     = golden[idx*FIELDS];
        op       = golden[idx*FIELDS+1];
        word     = golden[idx*FIELDS+2];
        dividend = golden[idx*FIELDS+3];
        divisor  = golden[idx*FIELDS+4];
        expected = golden[idx*FIELDS+5];
        wait_ready();
        case (kind)
            KIND_NORMAL: begin
                send_request(op, word, dividend, divisor, 1'b0);
                collect_result(expected);
            end
            KIND_FLUSH_MID: begin
                send_request(op, word, dividend, divisor, 1'b0);
                hold_busy(FLUSH_DELAY);
                flush_idle();
                watch_quiet(LATENCY + 5);
            end
            KIND_FLUSH_NEW: begin
                // this one gets aborted by the flush below
                send_request(64'd1, 64'd0, 64'h0fed_cba9_8765_4321, 64'd3, 1'b0);
                hold_busy(FLUSH_DELAY);
                send_request(op, word, dividend, divisor, 1'b1);
                collect_result(expected);
            end
            default: begin
                $display("golden file holds an unknown vector kind at line %0d", idx);
                $display("Checks failed");
                $fatal(1);
            end
        endcase
    endtask

    // **********************************************************************
    // main sequence
    // **********************************************************************
    initial begin : main
        int i;
        rst       = 1'b1;
        div_valid = 1'b0;
        flush     = 1'b0;
        req       = '0;

        for (i = 0; i < MAX_VECTORS*FIELDS; i++) begin
            golden[i] = FILL_BASE | 64'(i);  // marks lines the file leaves out
        end
        $readmemh("sim/div_golden.txt", golden);

        n_vec   = 0;
        n_flush = 0;
        while (n_vec < MAX_VECTORS &&
               golden[n_vec*FIELDS] != (FILL_BASE | 64'(n_vec*FIELDS))) begin
            if (golden[n_vec*FIELDS] != KIND_NORMAL) begin
                n_flush++;
            end
            n_vec++;
        end
        if (n_vec == 0) begin
            $display("no vectors could be read from sim/div_golden.txt");
            $display("Checks failed");
            $fatal(1);
        end
        cycle_limit = n_vec * 70 + n_flush * 40 + 200;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("div_ready", 64'(div_ready), 64'd1);
        check_value("out_valid", 64'(out_valid), 64'd0);

        for (i = 0; i < n_vec; i++) begin
            run_vector(i);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/div_golden.txt ====
// kind op word dividend divisor expected, all hex
// kind 0 normal, 1 flush mid-operation, 2 flush with a new request; op 0 div, 1 divu, 2 rem, 3 remu
0 1 0 0000000000000064 0000000000000007 000000000000000e
0 3 0 0000000000000064 0000000000000007 0000000000000002
0 0 0 0000000000000064 0000000000000007 000000000000000e
0 0 0 ffffffffffffff9c 0000000000000007 fffffffffffffff2
0 0 0 0000000000000064 fffffffffffffff9 fffffffffffffff2
0 0 0 ffffffffffffff9c fffffffffffffff9 000000000000000e
0 2 0 0000000000000064 0000000000000007 0000000000000002
0 2 0 ffffffffffffff9c 0000000000000007 fffffffffffffffe
0 2 0 0000000000000064 fffffffffffffff9 0000000000000002
0 2 0 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe
0 1 0 ffffffffffffffff 0000000000000002 7fffffffffffffff
0 3 0 ffffffffffffffff 0000000000000002 0000000000000001
0 1 0 ffffffffffffff9c 0000000000000007 2492492492492484
0 3 0 ffffffffffffff9c 0000000000000007 0000000000000000
0 0 0 8000000000000000 0000000000000002 c000000000000000
0 0 0 8000000000000000 0000000000000003 d555555555555556
0 2 0 8000000000000000 0000000000000003 fffffffffffffffe
0 1 0 8000000000000000 0000000000000003 2aaaaaaaaaaaaaaa
0 3 0 8000000000000000 0000000000000003 0000000000000002
0 1 0 0000000000000005 0000000000000009 0000000000000000
0 3 0 0000000000000005 0000000000000009 0000000000000005
0 0 0 123456789abcdef0 0000000000000010 0123456789abcdef
0 0 0 7fffffffffffffff 7fffffffffffffff 0000000000000001
0 0 0 0000000000000007 ffffffffffffff9c 0000000000000000
0 2 0 0000000000000007 ffffffffffffff9c 0000000000000007
0 1 0 0000000000001234 0000000000000000 ffffffffffffffff
0 3 0 0000000000001234 0000000000000000 0000000000001234
0 0 0 fffffffffffffffb 0000000000000000 ffffffffffffffff
0 2 0 fffffffffffffffb 0000000000000000 fffffffffffffffb
0 0 0 8000000000000000 ffffffffffffffff 8000000000000000
0 2 0 8000000000000000 ffffffffffffffff 0000000000000000
0 0 1 deadbeef00000064 cafebabe00000007 000000000000000e
0 0 1 12345678ffffff9c 0000000100000007 fffffffffffffff2
0 2 1 12345678ffffff9c 0000000100000007 fffffffffffffffe
0 1 1 abcdef01ffffffff 5555555500000002 000000007fffffff
0 1 1 00000000fffffffe ffffffff00000001 fffffffffffffffe
0 3 1 77777777ffffff9c 8888888800000007 0000000000000002
0 0 1 12345678fffffff6 abcdef0000000000 ffffffffffffffff
0 2 1 12345678fffffff6 abcdef0000000000 fffffffffffffff6
0 3 1 1234567887654321 ffffffff00000000 ffffffff87654321
0 1 1 1234567887654321 ffffffff00000000 ffffffffffffffff
0 0 1 0000000080000000 00000000ffffffff ffffffff80000000
0 2 1 0000000080000000 00000000ffffffff 0000000000000000
0 0 1 999999997fffffff 1111111100000010 0000000007ffffff
1 1 0 0000000000001234 0000000000000003 0000000000000000
0 1 0 0000000000001234 0000000000000010 0000000000000123
2 0 0 ffffffffffffff9c 0000000000000007 fffffffffffffff2
1 2 0 ffffffffffffff9c 0000000000000007 0000000000000000
2 3 0 0000000000000064 0000000000000007 0000000000000002

// ==== src.f ====
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_radix2_core.sv
logic/div_result_fixup.sv
logic/div_unit.sv
sim/div_unit_tb.sv

// ==== Makefile ====
# Verilator flow for the divide unit, run from the project root

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= div_unit_tb
RTL_TOP    ?= div_unit
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   := All checks passed
RTL_SRCS   := $(shell grep '^logic/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(TB_TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
